// ==== bcd_add.f ====
+incdir+rtl
rtl/bcd_add_pkg.sv
rtl/bcd_digit_adder.sv
rtl/bcd_add_controller.sv
rtl/bcd_add_datapath.sv
rtl/bcd_add_top.sv
testbench/bcd_add_sva.sv
testbench/bcd_add_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the BCD adder testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f bcd_add.f \
	--top-module bcd_add_tb

# The testbench stops with a non-zero status on failure; the log decides.
./obj_dir/Vbcd_add_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
	echo "run_sim: test run passed"
else
	echo "run_sim: test run failed"
	exit 1
fi

// ==== testbench/bcd_add_tb.sv ====
`timescale 1ns/100ps
`include "bcd_add_defs.svh"

module bcd_add_tb;

	localparam int OP_W          = `BCD_OP_W;
	localparam int SUM_W         = 4 * `BCD_SUM_DIGITS;
	localparam int TIMEOUT_CYCLES = 40;

	// DUT inputs.
	logic                   CLK = 1'b0;
	logic                   arst_n;
	bcd_add_pkg::user_req_t req;
	logic [OP_W-1:0]        sw_value;

	// DUT outputs.
	logic [OP_W-1:0]        disp_value;
	bcd_add_pkg::disp_src_e disp_src;
	logic                   operand_invalid;

	bcd_add_top DUT (
		.CLK             (CLK),
		.arst_n          (arst_n),
		.req             (req),
		.sw_value        (sw_value),
		.disp_value      (disp_value),
		.disp_src        (disp_src),
		.operand_invalid (operand_invalid)
	);

	// 10 ns clock.
	always #5 CLK = ~CLK;

	////////////////////////////////////////////////////////////
	// Helpers.
	////////////////////////////////////////////////////////////

	// Move to 1 ns after the next rising edge.
	task automatic step_clock();
		@(posedge CLK);
		#1;
	endtask

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Simulation FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			fail_run($sformatf("FAIL time %0t: %s = 0x%0h, expected 0x%0h",
				$time, name, actual, expected));
		end
	endtask

	// Bounded wait for the display source to move off old_src.
	task automatic wait_src_change(input bcd_add_pkg::disp_src_e old_src);
		int cycles;
		cycles = 0;
		while (disp_src == old_src && cycles < TIMEOUT_CYCLES) begin
			step_clock();
			cycles++;
		end
		if (disp_src == old_src) begin
			fail_run($sformatf("Display source stayed at %s for %0d cycles",
				old_src.name(), TIMEOUT_CYCLES));
		end
	endtask

	function automatic bcd_add_pkg::user_req_t make_req(input logic la, input logic lb,
		input logic ls, input logic ms);
		bcd_add_pkg::user_req_t r;
		r.load_a     = la;
		r.load_b     = lb;
		r.display_ls = ls;
		r.display_ms = ms;
		return r;
	endfunction

	// Hold buttons until the display source changes, then release.
	task automatic press_button(input bcd_add_pkg::user_req_t buttons,
		input bcd_add_pkg::disp_src_e expected_src);
		req = buttons;
		wait_src_change(disp_src);
		req = '0;
		check_value("disp_src", 32'(disp_src), 32'(expected_src));
	endtask

	////////////////////////////////////////////////////////////
	// Reference model.
	////////////////////////////////////////////////////////////

	// Decimal value of a BCD word.
	function automatic int bcd_to_int(input logic [OP_W-1:0] value);
		int v;
		v = 0;
		for (int i = `BCD_DIGITS - 1; i >= 0; i--) begin
			v = v * 10 + int'(value[4*i +: 4]);
		end
		return v;
	endfunction

	// Decimal sum, split back into digits.
	function automatic logic [SUM_W-1:0] ref_sum(input logic [OP_W-1:0] a,
		input logic [OP_W-1:0] b);
		int total;
		logic [SUM_W-1:0] result;
		total = bcd_to_int(a) + bcd_to_int(b);
		for (int i = 0; i < `BCD_SUM_DIGITS; i++) begin
			result[4*i +: 4] = 4'(total % 10);
			total = total / 10;
		end
		return result;
	endfunction

	function automatic logic [OP_W-1:0] random_bcd();
		logic [OP_W-1:0] r;
		for (int i = 0; i < `BCD_DIGITS; i++) begin
			r[4*i +: 4] = 4'($urandom % 10);
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Directed tests.
	////////////////////////////////////////////////////////////

	// Load B then A, show both halves of the sum.
	task automatic run_sum(input logic [OP_W-1:0] a, input logic [OP_W-1:0] b);
		logic [SUM_W-1:0] expected;
		expected = ref_sum(a, b);
		sw_value = b;
		press_button(make_req(1'b0, 1'b1, 1'b0, 1'b0), bcd_add_pkg::SRC_B);
		check_value("disp_value", 32'(disp_value), 32'(b));
		sw_value = a;
		press_button(make_req(1'b1, 1'b0, 1'b0, 1'b0), bcd_add_pkg::SRC_A);
		check_value("disp_value", 32'(disp_value), 32'(a));
		press_button(make_req(1'b0, 1'b0, 1'b1, 0), bcd_add_pkg::SRC_SUM_LS);
		check_value("disp_value", 32'(disp_value), 32'(expected[OP_W-1:0]));
		press_button(make_req(1'b0, 1'b0, 1'b0, 1'b1), bcd_add_pkg::SRC_SUM_MS);
		check_value("disp_value", 32'(disp_value), 32'(OP_W'(expected >> OP_W)));
	endtask

	// Automatic first load of A after reset.
	task automatic test_reset_load();
		wait_src_change(bcd_add_pkg::SRC_NONE);
		check_value("disp_src", 32'(disp_src), 32'(bcd_add_pkg::SRC_A));
		check_value("disp_value", 32'(disp_value), 32'(OP_W'('h37)));
		check_value("operand_invalid", 32'(operand_invalid), 32'd0);
	endtask

	task automatic test_loading();
		sw_value = OP_W'('h58);
		press_button(make_req(1'b0, 1'b1, 1'b0, 1'b0), bcd_add_pkg::SRC_B);
		check_value("disp_value", 32'(disp_value), 32'(OP_W'('h58)));
		sw_value = OP_W'('h26);
		press_button(make_req(1'b1, 1'b0, 1'b0, 1'b0), bcd_add_pkg::SRC_A);
		check_value("disp_value", 32'(disp_value), 32'(OP_W'('h26)));
	endtask

	// Carry cases and edge values.
	task automatic test_fixed_sums();
		run_sum(OP_W'('h99), OP_W'('h01));
		run_sum(OP_W'('h45), OP_W'('h32));
		run_sum(OP_W'('h50), OP_W'('h50));
		run_sum(OP_W'('h99), OP_W'('h99));
		run_sum(OP_W'('h00), OP_W'('h00));
		run_sum(OP_W'('h19), OP_W'('h81));
	endtask

	task automatic test_random_sums();
		logic [OP_W-1:0] a;
		logic [OP_W-1:0] b;
		for (int n = 0; n < 20; n++) begin
			a = random_bcd();
			b = random_bcd();
			run_sum(a, b);
		end
	endtask

	// Buttons pressed together.
	task automatic test_priority();
		press_button(make_req(1'b1, 1'b1, 1'b0, 1'b0), bcd_add_pkg::SRC_B);
		press_button(make_req(1'b0, 1'b0, 1'b1, 1'b1), bcd_add_pkg::SRC_SUM_MS);
	endtask

	// Bad digit sets the sticky flag.
	task automatic test_validity();
		check_value("operand_invalid", 32'(operand_invalid), 32'd0);
		sw_value = OP_W'('h5C);
		press_button(make_req(1'b1, 1'b0, 1'b0, 1'b0), bcd_add_pkg::SRC_A);
		check_value("disp_value", 32'(disp_value), 32'(OP_W'('h5C)));
		check_value("operand_invalid", 32'(operand_invalid), 32'd1);
		sw_value = OP_W'('h12);
		press_button(make_req(1'b0, 1'b1, 1'b0, 1'b0), bcd_add_pkg::SRC_B);
		check_value("operand_invalid", 32'(operand_invalid), 32'd1);
		sw_value = OP_W'('h34);
		press_button(make_req(1'b1, 1'b0, 1'b0, 1'b0), bcd_add_pkg::SRC_A);
		check_value("operand_invalid", 32'(operand_invalid), 32'd1);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence.
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(24166));
		arst_n   = 1'b0;
		req      = '0;
		// Value that the first automatic load of A picks up.
		sw_value = OP_W'('h37);
		repeat (8) @(posedge CLK);
		#1;
		check_value("disp_src", 32'(disp_src), 32'(bcd_add_pkg::SRC_NONE));
		check_value("disp_value", 32'(disp_value), 32'd0);
		check_value("operand_invalid", 32'(operand_invalid), 32'd0);
		arst_n = 1'b1;

		test_reset_load();
		test_loading();
		test_fixed_sums();
		test_random_sums();
		test_priority();
		test_validity();

		// Bound controller assertions count their own failures.
		if (DUT.u_controller.u_sva.assert_failures == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			fail_run("Controller assertions failed during the run");
		end
	end

endmodule

// ==== testbench/bcd_add_sva.sv ====
`timescale 1ns/100ps

module bcd_add_sva (
	input logic                     CLK,
	input logic                     arst_n,
	input bcd_add_pkg::dp_cmd_t     cmd,
	input bcd_add_pkg::dp_ack_t     ack,
	input bcd_add_pkg::ctrl_state_e state
);

	// Command struct as a flat vector.
	logic [5:0] cmd_bits;

	// Failed assertions so far.
	int assert_failures = 0;

	assign cmd_bits = cmd;

	////////////////////////////////////////////////////////////
	// Controller properties.
	////////////////////////////////////////////////////////////

	// Never two commands at once.
	a_one_cmd: assert property (@(posedge CLK) disable iff (!arst_n)
		$onehot0(cmd_bits))
		else begin
			assert_failures = assert_failures + 1;
			$error("More than one command field is high");
		end

	// Load A held while its ack is low.
	a_hold_load_a: assert property (@(posedge CLK) disable iff (!arst_n)
		(cmd.load_a && !ack.load_a) |=> cmd.load_a)
		else begin
			assert_failures = assert_failures + 1;
			$error("load_a command dropped before its ack");
		end

	// Same for load B.
	a_hold_load_b: assert property (@(posedge CLK) disable iff (!arst_n)
		(cmd.load_b && !ack.load_b) |=> cmd.load_b)
		else begin
			assert_failures = assert_failures + 1;
			$error("load_b command dropped before its ack");
		end

	// First clock after reset release sees the clear-all state.
	a_init_after_reset: assert property (@(posedge CLK)
		$rose(arst_n) |-> (state == bcd_add_pkg::ST_INIT))
		else begin
			assert_failures = assert_failures + 1;
			$error("Controller not in ST_INIT after reset");
		end

endmodule

// Attach to every controller instance.
bind bcd_add_controller bcd_add_sva u_sva (
	.CLK    (CLK),
	.arst_n (arst_n),
	.cmd    (cmd),
	.ack    (ack),
	.state  (state)
);

// ==== rtl/bcd_add_top.sv ====
`timescale 1ns/100ps
`include "bcd_add_defs.svh"

module bcd_add_top (
	input  logic                   CLK,
	input  logic                   arst_n,
	input  bcd_add_pkg::user_req_t req,
	input  logic [`BCD_OP_W-1:0]   sw_value,
	output logic [`BCD_OP_W-1:0]   disp_value,
	output bcd_add_pkg::disp_src_e disp_src,
	output logic                   operand_invalid
);

	////////////////////////////////////////////////////////////
	// Internal handshake.
	////////////////////////////////////////////////////////////

	// Command levels to the datapath.
	bcd_add_pkg::dp_cmd_t cmd;

	// Acknowledge levels back to the controller.
	bcd_add_pkg::dp_ack_t ack;

	// Sequencing FSM.
	bcd_add_controller u_controller (
		.CLK    (CLK),
		.arst_n (arst_n),
		.req    (req),
		.ack    (ack),
		.cmd    (cmd)
	);

	// Operands, adder chain and display.
	bcd_add_datapath u_datapath (
		.CLK             (CLK),
		.arst_n          (arst_n),
		.cmd             (cmd),
		.sw_value        (sw_value),
		.ack             (ack),
		.disp_value      (disp_value),
		.disp_src        (disp_src),
		.operand_invalid (operand_invalid)
	);

endmodule

// ==== rtl/bcd_add_datapath.sv ====
`timescale 1ns/100ps
`include "bcd_add_defs.svh"

module bcd_add_datapath (
	input  logic                   CLK,
	input  logic                   arst_n,
	input  bcd_add_pkg::dp_cmd_t   cmd,
	input  logic [`BCD_OP_W-1:0]   sw_value,
	output bcd_add_pkg::dp_ack_t   ack,
	output logic [`BCD_OP_W-1:0]   disp_value,
	output bcd_add_pkg::disp_src_e disp_src,
	output logic                   operand_invalid
);

	localparam int OP_W  = `BCD_OP_W;
	localparam int SUM_W = 4 * `BCD_SUM_DIGITS;

	// Operand registers.
	logic [OP_W-1:0] op_a;
	logic [OP_W-1:0] op_b;

	// Digit carry chain, bit 0 is the chain input.
	logic [`BCD_DIGITS:0] carry;

	// Sum digits and halves.
	logic [OP_W-1:0]  sum_low;
	logic [SUM_W-1:0] sum_full;
	logic [OP_W-1:0]  sum_ms;

	// Switch value holds a digit above nine.
	logic sw_bad;

	// Any digit of the value above nine.
	function automatic logic has_bad_digit(input logic [OP_W-1:0] value);
		logic bad;
		bad = 1'b0;
		for (int i = 0; i < `BCD_DIGITS; i++) begin
			if (value[4*i +: 4] > 4'd9) begin
				bad = 1'b1;
			end
		end
		return bad;
	endfunction

	////////////////////////////////////////////////////////////
	// Adder chain.
	////////////////////////////////////////////////////////////

	assign carry[0] = 1'b0;

	// Ripple from the least significant digit.
	for (genvar g = 0; g < `BCD_DIGITS; g++) begin : g_digit
		bcd_digit_adder u_digit (
			.a         (op_a[4*g +: 4]),
			.b         (op_b[4*g +: 4]),
			.carry_in  (carry[g]),
			.sum       (sum_low[4*g +: 4]),
			.carry_out (carry[g+1])
		);
	end

	// Final carry becomes the top digit.
	assign sum_full = {3'b000, carry[`BCD_DIGITS], sum_low};

	// Upper digits right-aligned, zero-filled.
	assign sum_ms = OP_W'(sum_full >> OP_W);

	assign sw_bad = has_bad_digit(sw_value);

	////////////////////////////////////////////////////////////
	// Registers.
	////////////////////////////////////////////////////////////

	// Operands follow the load commands.
	always_ff @(posedge CLK) begin
		if (cmd.load_a) begin
			op_a <= sw_value;
		end
		if (cmd.load_b) begin
			op_b <= sw_value;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			ack             <= '0;
			disp_value      <= '0;
			disp_src        <= bcd_add_pkg::SRC_NONE;
			operand_invalid <= 1'b0;
		end else begin
			// Ack is the command one cycle late.
			ack <= cmd;

			// Controller raises at most one display command.
			if (cmd.display_a) begin
				disp_value <= op_a;
				disp_src   <= bcd_add_pkg::SRC_A;
			end else if (cmd.display_b) begin
				disp_value <= op_b;
				disp_src   <= bcd_add_pkg::SRC_B;
			end else if (cmd.display_ls) begin
				disp_value <= sum_low;
				disp_src   <= bcd_add_pkg::SRC_SUM_LS;
			end else if (cmd.display_ms) begin
				disp_value <= sum_ms;
				disp_src   <= bcd_add_pkg::SRC_SUM_MS;
			end

			// Sticky until reset.
			if ((cmd.load_a || cmd.load_b) && sw_bad) begin
				operand_invalid <= 1'b1;
			end
		end
	end

endmodule

// ==== rtl/bcd_add_controller.sv ====
`timescale 1ns/100ps

module bcd_add_controller (
	input  logic                   CLK,
	input  logic                   arst_n,
	input  bcd_add_pkg::user_req_t req,
	input  bcd_add_pkg::dp_ack_t   ack,
	output bcd_add_pkg::dp_cmd_t   cmd
);

	// Current FSM state.
	bcd_add_pkg::ctrl_state_e state;

	////////////////////////////////////////////////////////////
	// Button decode.
	////////////////////////////////////////////////////////////

	// Next state from the buttons after a display ack.
	// Priority is display_ms, display_ls, load_b, load_a.
	// No button keeps the current state.
	function automatic bcd_add_pkg::ctrl_state_e button_next(
		input bcd_add_pkg::user_req_t     buttons,
		input bcd_add_pkg::ctrl_state_e   current
	);
		bcd_add_pkg::ctrl_state_e nxt;
		nxt = current;
		if (buttons.display_ms) begin
			nxt = bcd_add_pkg::ST_DISPLAY_MS;
		end else if (buttons.display_ls) begin
			nxt = bcd_add_pkg::ST_DISPLAY_LS;
		end else if (buttons.load_b) begin
			nxt = bcd_add_pkg::ST_LOAD_B;
		end else if (buttons.load_a) begin
			nxt = bcd_add_pkg::ST_LOAD_A;
		end
		return nxt;
	endfunction

	////////////////////////////////////////////////////////////
	// Sequencing FSM.
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= bcd_add_pkg::ST_INIT;
			cmd   <= '0;
		end else begin
			// One command field per state.
			// Everything else low by default.
			cmd <= '0;
			case (state)
				bcd_add_pkg::ST_INIT: begin
					// Single clear-all cycle.
					state <= bcd_add_pkg::ST_LOAD_A;
				end

				bcd_add_pkg::ST_LOAD_A: begin
					// Hold load until the datapath answers.
					cmd.load_a <= 1'b1;
					if (ack.load_a) begin
						state <= bcd_add_pkg::ST_DISPLAY_A;
					end
				end

				bcd_add_pkg::ST_DISPLAY_A: begin
					// Show A, then drop the command for a cycle.
					if (ack.display_a) begin
						state <= button_next(req, state);
					end else begin
						cmd.display_a <= 1'b1;
					end
				end

				bcd_add_pkg::ST_LOAD_B: begin
					cmd.load_b <= 1'b1;
					if (ack.load_b) begin
						state <= bcd_add_pkg::ST_DISPLAY_B;
					end
				end

				bcd_add_pkg::ST_DISPLAY_B: begin
					if (ack.display_b) begin
						state <= button_next(req, state);
					end else begin
						cmd.display_b <= 1'b1;
					end
				end

				bcd_add_pkg::ST_DISPLAY_LS: begin
					// Low half of the sum.
					if (ack.display_ls) begin
						state <= button_next(req, state);
					end else begin
						cmd.display_ls <= 1'b1;
					end
				end

				bcd_add_pkg::ST_DISPLAY_MS: begin
					// High half of the sum.
					if (ack.display_ms) begin
						state <= button_next(req, state);
					end else begin
						cmd.display_ms <= 1'b1;
					end
				end

				default: begin
					// Unused code, restart.
					state <= bcd_add_pkg::ST_INIT;
				end
			endcase
		end
	end

endmodule

// ==== rtl/bcd_digit_adder.sv ====
`timescale 1ns/100ps

module bcd_digit_adder (
	input  logic [3:0] a,
	input  logic [3:0] b,
	input  logic       carry_in,
	output logic [3:0] sum,
	output logic       carry_out
);

	// Raw binary sum, at most 9 + 9 + 1 = 19.
	logic [4:0] bin_sum;

	// Result digit after the decimal correction.
	logic [3:0] adj_sum;

	// Plain binary addition of both digits and the carry.
	assign bin_sum = {1'b0, a} + {1'b0, b} + {4'b0000, carry_in};

	////////////////////////////////////////////////////////////
	// Decimal correction.
	////////////////////////////////////////////////////////////

	always_comb begin
		if (bin_sum > 5'd9) begin
			// Skip the six unused codes 10 to 15.
			// The sixteen wraps into carry_out.
			adj_sum   = bin_sum[3:0] + 4'd6;
			carry_out = 1'b1;
		end else begin
			// Already a valid digit.
			adj_sum   = bin_sum[3:0];
			carry_out = 1'b0;
		end
	end

	// Corrected result digit.
	assign sum = adj_sum;

endmodule

// ==== rtl/bcd_add_pkg.sv ====
package bcd_add_pkg;

	////////////////////////////////////////////////////////////
	// Encodings.
	////////////////////////////////////////////////////////////

	// Controller FSM states.
	typedef enum logic [2:0] {
		ST_INIT,
		ST_LOAD_A,
		ST_DISPLAY_A,
		ST_LOAD_B,
		ST_DISPLAY_B,
		ST_DISPLAY_LS,
		ST_DISPLAY_MS
	} ctrl_state_e;

	// Source of the value on the display.
	typedef enum logic [2:0] {
		SRC_NONE,
		SRC_A,
		SRC_B,
		SRC_SUM_LS,
		SRC_SUM_MS
	} disp_src_e;

	////////////////////////////////////////////////////////////
	// Flag groups.
	////////////////////////////////////////////////////////////

	// User buttons, plain levels.
	typedef struct packed {
		logic load_a;
		logic load_b;
		logic display_ls;
		logic display_ms;
	} user_req_t;

	// Controller to datapath commands.
	typedef struct packed {
		logic load_a;
		logic load_b;
		logic display_a;
		logic display_b;
		logic display_ls;
		logic display_ms;
	} dp_cmd_t;

	// Datapath acknowledges, one per command.
	typedef struct packed {
		logic load_a;
		logic load_b;
		logic display_a;
		logic display_b;
		logic display_ls;
		logic display_ms;
	} dp_ack_t;

endpackage

// ==== rtl/bcd_add_defs.svh ====
`ifndef BCD_ADD_DEFS_SVH
`define BCD_ADD_DEFS_SVH

////////////////////////////////////////////////////////////
// Operand size.
////////////////////////////////////////////////////////////

// Decimal digits per operand, 1 to 4.
`define BCD_DIGITS 2

// Bits in one operand, four per digit.
`define BCD_OP_W (4 * `BCD_DIGITS)

// Digits in the sum.
// One extra digit holds the final carry.
`define BCD_SUM_DIGITS (`BCD_DIGITS + 1)

`endif
